/* source/fib_pkg.sv */
// FIB table shared definitions
`default_nettype none

package fib_pkg;

    // Packet field widths
    localparam int unsigned PREFIX_W = 64;
    localparam int unsigned META_W   = 8;
    localparam int unsigned BYTE_W   = 8;

    // Table geometry
    localparam int unsigned HASH_W      = 10;
    localparam int unsigned LEN_W       = 6;
    localparam int unsigned NUM_LENGTHS = 64;

    // Stream framing
    localparam int unsigned PREFIX_BYTES = 8;
    localparam int unsigned RESP_BYTES   = 17;

    typedef logic [PREFIX_W-1:0] prefix_t;
    // Bits 5:0 hold the prefix length
    typedef logic [META_W-1:0]   meta_t;
    typedef logic [BYTE_W-1:0]   byte_t;
    typedef logic [HASH_W-1:0]   hash_t;
    // Length doubles as the table row
    typedef logic [LEN_W-1:0]    len_t;

    // Announcement parser
    typedef enum logic [1:0] {
        ING_IDLE,
        ING_PREFIX,
        ING_HASH,
        ING_WRITE
    } ingest_state_e;

    // Longest-prefix search, one probe is hash, read, decide
    typedef enum logic [2:0] {
        SRCH_IDLE,
        SRCH_HASH,
        SRCH_READ,
        SRCH_DECIDE,
        SRCH_HANDOFF
    } search_state_e;

    // Response serializer sections
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_META,
        TX_TOTAL,
        TX_LONGEST
    } tx_state_e;

endpackage

`default_nettype wire

/* source/fib_hash.sv */
// Prefix fold hash
`default_nettype none

module fib_hash (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire fib_pkg::prefix_t prefix,
    output fib_pkg::hash_t       hash
);

    fib_pkg::hash_t fold;

    // XOR of six full 10-bit chunks from the LSB
    // Top 4 bits zero-extended into a seventh chunk
    always_comb begin
        fold = '0;
        for (int i = 0; i < 6; i++) begin
            fold = fold ^ prefix[i*fib_pkg::HASH_W +: fib_pkg::HASH_W];
        end
        fold = fold ^ {6'b0, prefix[fib_pkg::PREFIX_W-1 -: 4]};
    end

    // Hash is available on the next edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hash <= '0;
        end else begin
            hash <= fold;
        end
    end

endmodule

`default_nettype wire

/* source/fib_ingest.sv */
// Announcement parser
`default_nettype none

module fib_ingest (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             rx_valid,
    output logic                  rx_ready,
    input  wire fib_pkg::byte_t   rx_byte,
    output fib_pkg::prefix_t      hash_prefix,
    input  wire fib_pkg::hash_t   hash,
    output logic                  wr_en,
    output fib_pkg::len_t         wr_len,
    output fib_pkg::hash_t        wr_hash
);

    fib_pkg::ingest_state_e state;
    fib_pkg::meta_t         meta;
    fib_pkg::prefix_t       prefix;
    // Prefix bytes still to come, minus one
    logic [2:0]             byte_cnt;
    logic                   rx_fire;

    // Stream is open while collecting bytes
    assign rx_ready = (state == fib_pkg::ING_IDLE) || (state == fib_pkg::ING_PREFIX);
    assign rx_fire  = rx_valid && rx_ready;

    // Hash unit sees the prefix register at all times
    assign hash_prefix = prefix;

    // Write strobe for one cycle
    // Hash is already registered by then
    assign wr_en   = (state == fib_pkg::ING_WRITE);
    assign wr_len  = meta[fib_pkg::LEN_W-1:0];
    assign wr_hash = hash;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fib_pkg::ING_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                fib_pkg::ING_IDLE: begin
                    // Metadata byte opens an announcement
                    if (rx_fire) begin
                        byte_cnt <= 3'(fib_pkg::PREFIX_BYTES - 1);
                        state    <= fib_pkg::ING_PREFIX;
                    end
                end
                fib_pkg::ING_PREFIX: begin
                    if (rx_fire) begin
                        byte_cnt <= byte_cnt - 1'b1;
                        // Last prefix byte
                        if (byte_cnt == '0) begin
                            state <= fib_pkg::ING_HASH;
                        end
                    end
                end
                fib_pkg::ING_HASH: begin
                    // Hash unit registers the full prefix here
                    state <= fib_pkg::ING_WRITE;
                end
                fib_pkg::ING_WRITE: begin
                    state <= fib_pkg::ING_IDLE;
                end
                default: begin
                    state <= fib_pkg::ING_IDLE;
                end
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (rx_fire && (state == fib_pkg::ING_IDLE)) begin
            meta <= rx_byte;
        end
        // Bytes arrive MSB first and shift in from the bottom
        if (rx_fire && (state == fib_pkg::ING_PREFIX)) begin
            prefix <= {prefix[fib_pkg::PREFIX_W-fib_pkg::BYTE_W-1:0], rx_byte};
        end
    end

endmodule

`default_nettype wire

/* source/fib_valid_table.sv */
// Prefix valid-bit table
`default_nettype none

module fib_valid_table (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           wr_en,
    input  wire fib_pkg::len_t  wr_len,
    input  wire fib_pkg::hash_t wr_hash,
    input  wire fib_pkg::len_t  rd_len,
    input  wire fib_pkg::hash_t rd_hash,
    output logic                rd_bit
);

    // One row per prefix length, one column per hash value
    logic [2**fib_pkg::HASH_W-1:0] valid_bits [fib_pkg::NUM_LENGTHS];

    // Write port sets a single bit
    // Reset empties the whole table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int row = 0; row < fib_pkg::NUM_LENGTHS; row++) begin
                valid_bits[row] <= '0;
            end
        end else if (wr_en) begin
            valid_bits[wr_len][wr_hash] <= 1'b1;
        end
    end

    // Registered read
    // Same-cycle write to the same bit is not seen until the next read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_bit <= 1'b0;
        end else begin
            rd_bit <= valid_bits[rd_len][rd_hash];
        end
    end

endmodule

`default_nettype wire

/* source/fib_lpm_search.sv */
// Longest-prefix search FSM
`default_nettype none

module fib_lpm_search (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             lookup_valid,
    output logic                  lookup_ready,
    input  wire fib_pkg::prefix_t lookup_prefix,
    input  wire fib_pkg::meta_t   lookup_metadata,
    output fib_pkg::prefix_t      hash_prefix,
    input  wire fib_pkg::hash_t   hash,
    output fib_pkg::len_t         rd_len,
    output fib_pkg::hash_t        rd_hash,
    input  wire logic             rd_bit,
    output logic                  job_valid,
    input  wire logic             job_ready,
    output fib_pkg::meta_t        job_meta,
    output fib_pkg::prefix_t      job_total,
    output fib_pkg::prefix_t      job_longest
);

    fib_pkg::search_state_e state;
    fib_pkg::meta_t         meta;
    // Request as received
    fib_pkg::prefix_t       total;
    // Prefix being narrowed down by the probe loop
    fib_pkg::prefix_t       cur_prefix;
    fib_pkg::len_t          len;
    logic                   lookup_fire;
    logic                   done;

    // One request at a time
    assign lookup_ready = (state == fib_pkg::SRCH_IDLE);
    assign lookup_fire  = lookup_valid && lookup_ready;

    // Hash unit follows the current prefix
    assign hash_prefix = cur_prefix;

    // Table probe at current length and hash
    assign rd_len  = len;
    assign rd_hash = hash;

    // Hit ends the search, so does a miss at length 0
    assign done = rd_bit || (len == '0);

    // Job offered to the serializer
    assign job_valid   = (state == fib_pkg::SRCH_HANDOFF);
    assign job_meta    = meta;
    assign job_total   = total;
    assign job_longest = cur_prefix;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fib_pkg::SRCH_IDLE;
        end else begin
            case (state)
                fib_pkg::SRCH_IDLE: begin
                    if (lookup_fire) begin
                        state <= fib_pkg::SRCH_HASH;
                    end
                end
                // Hash of cur_prefix lands at the end of this cycle
                fib_pkg::SRCH_HASH: begin
                    state <= fib_pkg::SRCH_READ;
                end
                // Table read in flight
                fib_pkg::SRCH_READ: begin
                    state <= fib_pkg::SRCH_DECIDE;
                end
                fib_pkg::SRCH_DECIDE: begin
                    if (done) begin
                        state <= fib_pkg::SRCH_HANDOFF;
                    end else begin
                        state <= fib_pkg::SRCH_HASH;
                    end
                end
                // Hold until the serializer takes the job
                fib_pkg::SRCH_HANDOFF: begin
                    if (job_ready) begin
                        state <= fib_pkg::SRCH_IDLE;
                    end
                end
                default: begin
                    state <= fib_pkg::SRCH_IDLE;
                end
            endcase
        end
    end

    // Request latch and prefix narrowing
    always_ff @(posedge clk) begin
        if (lookup_fire) begin
            meta       <= lookup_metadata;
            total      <= lookup_prefix;
            cur_prefix <= lookup_prefix;
            len        <= lookup_metadata[fib_pkg::LEN_W-1:0];
        end else if ((state == fib_pkg::SRCH_DECIDE) && !done) begin
            // Miss, drop bit L and retry one length shorter
            cur_prefix[len] <= 1'b0;
            len             <= len - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/fib_tx_serializer.sv */
// Response byte serializer
`default_nettype none

module fib_tx_serializer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             job_valid,
    output logic                  job_ready,
    input  wire fib_pkg::meta_t   job_meta,
    input  wire fib_pkg::prefix_t job_total,
    input  wire fib_pkg::prefix_t job_longest,
    output logic                  tx_valid,
    input  wire logic             tx_ready,
    output fib_pkg::byte_t        tx_byte,
    output logic                  tx_last
);

    fib_pkg::tx_state_e state;
    fib_pkg::meta_t     meta;
    fib_pkg::prefix_t   total_sr;
    fib_pkg::prefix_t   longest_sr;
    // Index of the byte on the bus, 0 to 16
    logic [4:0]         byte_cnt;
    logic               job_fire;
    logic               tx_fire;

    // Single job buffer
    assign job_ready = (state == fib_pkg::TX_IDLE);
    assign job_fire  = job_valid && job_ready;

    assign tx_valid = (state != fib_pkg::TX_IDLE);
    assign tx_fire  = tx_valid && tx_ready;
    assign tx_last  = (byte_cnt == 5'(fib_pkg::RESP_BYTES - 1));

    // Byte select, top byte of each shift register
    always_comb begin
        case (state)
            fib_pkg::TX_META:    tx_byte = meta;
            fib_pkg::TX_TOTAL:   tx_byte = total_sr[fib_pkg::PREFIX_W-1 -: fib_pkg::BYTE_W];
            fib_pkg::TX_LONGEST: tx_byte = longest_sr[fib_pkg::PREFIX_W-1 -: fib_pkg::BYTE_W];
            default:             tx_byte = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fib_pkg::TX_IDLE;
            byte_cnt <= '0;
        end else begin
            if (job_fire) begin
                byte_cnt <= '0;
            end else if (tx_fire) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (state)
                fib_pkg::TX_IDLE: begin
                    if (job_fire) begin
                        state <= fib_pkg::TX_META;
                    end
                end
                fib_pkg::TX_META: begin
                    if (tx_fire) begin
                        state <= fib_pkg::TX_TOTAL;
                    end
                end
                fib_pkg::TX_TOTAL: begin
                    // Byte 8 closes the total prefix
                    if (tx_fire && (byte_cnt == 5'(fib_pkg::PREFIX_BYTES))) begin
                        state <= fib_pkg::TX_LONGEST;
                    end
                end
                fib_pkg::TX_LONGEST: begin
                    if (tx_fire && tx_last) begin
                        state <= fib_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= fib_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Load on job accept, shift only on accepted bytes
    always_ff @(posedge clk) begin
        if (job_fire) begin
            meta       <= job_meta;
            total_sr   <= job_total;
            longest_sr <= job_longest;
        end else if (tx_fire) begin
            if (state == fib_pkg::TX_TOTAL) begin
                total_sr <= total_sr << fib_pkg::BYTE_W;
            end
            if (state == fib_pkg::TX_LONGEST) begin
                longest_sr <= longest_sr << fib_pkg::BYTE_W;
            end
        end
    end

endmodule

`default_nettype wire

/* source/fib_table.sv */
// FIB table top level
`default_nettype none

module fib_table (
    input  wire logic             clk,
    input  wire logic             rst,
    // Host announcement stream
    input  wire logic             rx_valid,
    output logic                  rx_ready,
    input  wire fib_pkg::byte_t   rx_byte,
    // Lookup requests
    input  wire logic             lookup_valid,
    output logic                  lookup_ready,
    input  wire fib_pkg::prefix_t lookup_prefix,
    input  wire fib_pkg::meta_t   lookup_metadata,
    // Response stream
    output logic                  tx_valid,
    input  wire logic             tx_ready,
    output fib_pkg::byte_t        tx_byte,
    output logic                  tx_last
);

    // Learn side
    fib_pkg::prefix_t learn_prefix;
    fib_pkg::hash_t   learn_hash;
    logic             wr_en;
    fib_pkg::len_t    wr_len;
    fib_pkg::hash_t   wr_hash;

    // Search side
    fib_pkg::prefix_t search_prefix;
    fib_pkg::hash_t   search_hash;
    fib_pkg::len_t    rd_len;
    fib_pkg::hash_t   rd_hash;
    logic             rd_bit;

    // Search to serializer job
    logic             job_valid;
    logic             job_ready;
    fib_pkg::meta_t   job_meta;
    fib_pkg::prefix_t job_total;
    fib_pkg::prefix_t job_longest;

    fib_ingest u_ingest (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .rx_byte     (rx_byte),
        .hash_prefix (learn_prefix),
        .hash        (learn_hash),
        .wr_en       (wr_en),
        .wr_len      (wr_len),
        .wr_hash     (wr_hash)
    );

    fib_hash u_hash_learn (
        .clk    (clk),
        .rst    (rst),
        .prefix (learn_prefix),
        .hash   (learn_hash)
    );

    // Separate hash unit so learning and search never contend
    fib_hash u_hash_search (
        .clk    (clk),
        .rst    (rst),
        .prefix (search_prefix),
        .hash   (search_hash)
    );

    fib_valid_table u_valid_table (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_len  (wr_len),
        .wr_hash (wr_hash),
        .rd_len  (rd_len),
        .rd_hash (rd_hash),
        .rd_bit  (rd_bit)
    );

    fib_lpm_search u_lpm_search (
        .clk             (clk),
        .rst             (rst),
        .lookup_valid    (lookup_valid),
        .lookup_ready    (lookup_ready),
        .lookup_prefix   (lookup_prefix),
        .lookup_metadata (lookup_metadata),
        .hash_prefix     (search_prefix),
        .hash            (search_hash),
        .rd_len          (rd_len),
        .rd_hash         (rd_hash),
        .rd_bit          (rd_bit),
        .job_valid       (job_valid),
        .job_ready       (job_ready),
        .job_meta        (job_meta),
        .job_total       (job_total),
        .job_longest     (job_longest)
    );

    fib_tx_serializer u_tx_serializer (
        .clk         (clk),
        .rst         (rst),
        .job_valid   (job_valid),
        .job_ready   (job_ready),
        .job_meta    (job_meta),
        .job_total   (job_total),
        .job_longest (job_longest),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_byte     (tx_byte),
        .tx_last     (tx_last)
    );

endmodule

`default_nettype wire

/* verif/fib_table_props.sv */
// FIB table stream assertions
`default_nettype none

module fib_table_props (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           rx_ready,
    input wire logic           lookup_ready,
    input wire logic           tx_valid,
    input wire logic           tx_ready,
    input wire fib_pkg::byte_t tx_byte,
    input wire logic           tx_last
);
    timeunit 1ns;
    timeprecision 100ps;

    // Streams sit at their idle values while reset is held
    reset_values: assert property (@(posedge clk)
        rst |-> (!tx_valid && rx_ready && lookup_ready))
        else $error("Stream handshakes not at reset values during reset");

    // Stalled response byte must not change
    hold_payload: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> ($stable(tx_byte) && $stable(tx_last)))
        else $error("tx_byte or tx_last changed while stalled");

    // Offered byte stays offered until taken
    hold_valid: assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ready) |=> tx_valid)
        else $error("tx_valid dropped before transfer");

endmodule

bind fib_table fib_table_props u_props (
    .clk          (clk),
    .rst          (rst),
    .rx_ready     (rx_ready),
    .lookup_ready (lookup_ready),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_byte      (tx_byte),
    .tx_last      (tx_last)
);

`default_nettype wire

/* verif/fib_table_tb.sv */
// FIB table testbench
`default_nettype none

module fib_table_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_LOOKUPS      = 20;
    localparam int N_ANNOUNCE     = 7;
    // Worst-case search per lookup, plus stream bytes with stalls, plus slack
    localparam int TIMEOUT_CYCLES = N_LOOKUPS * 64 * 3
                                  + (N_ANNOUNCE * 9 + N_LOOKUPS * 17) * 4 + 1000;

    logic             clk;
    logic             rst;
    logic             rx_valid;
    logic             rx_ready;
    fib_pkg::byte_t   rx_byte;
    logic             lookup_valid;
    logic             lookup_ready;
    fib_pkg::prefix_t lookup_prefix;
    fib_pkg::meta_t   lookup_metadata;
    logic             tx_valid;
    logic             tx_ready;
    fib_pkg::byte_t   tx_byte;
    logic             tx_last;

    // Stimulus and back-pressure draw from separate streams of the same seed
    int               seed    = 32'h24f6_6f29;
    int               bp_seed = 32'h24f6_6f29 ^ 32'h0000_ffff;
    logic             bp_enable;
    logic             bp_now;
    int               cycle_count = 0;
    int               byte_errors = 0;
    int               last_errors = 0;
    int               proto_errors = 0;
    int               tx_seen = 0;

    // Table model, key is row and column
    bit               model_bits [int];
    fib_pkg::byte_t   exp_bytes [$];
    logic             exp_last [$];

    fib_pkg::prefix_t p2;
    fib_pkg::prefix_t p3;
    fib_pkg::prefix_t reduced;
    fib_pkg::prefix_t learned_prefix [5];
    fib_pkg::meta_t   learned_meta [5];

    fib_table u_fib_table (
        .clk             (clk),
        .rst             (rst),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .rx_byte         (rx_byte),
        .lookup_valid    (lookup_valid),
        .lookup_ready    (lookup_ready),
        .lookup_prefix   (lookup_prefix),
        .lookup_metadata (lookup_metadata),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready),
        .tx_byte         (tx_byte),
        .tx_last         (tx_last)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fold of 10-bit chunks, top nibble zero-extended
    function automatic fib_pkg::hash_t ref_hash(input fib_pkg::prefix_t p);
        fib_pkg::hash_t h;
        h = '0;
        for (int i = 0; i < 6; i++) begin
            h = h ^ p[i*10 +: 10];
        end
        return h ^ {6'b0, p[63:60]};
    endfunction

    function automatic int model_key(input fib_pkg::len_t l, input fib_pkg::hash_t h);
        return {16'b0, l, h};
    endfunction

    // Metadata, original prefix, then prefix where the search stops
    function automatic logic [8*17-1:0] ref_response(input fib_pkg::prefix_t p,
                                                     input fib_pkg::meta_t m);
        fib_pkg::prefix_t cur;
        fib_pkg::len_t    l;
        cur = p;
        l   = m[5:0];
        while (!model_bits.exists(model_key(l, ref_hash(cur))) && (l != 0)) begin
            cur[l] = 1'b0;
            l      = l - 1'b1;
        end
        return {m, p, cur};
    endfunction

    function automatic fib_pkg::prefix_t rand_prefix();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic check_byte(input fib_pkg::byte_t got, input fib_pkg::byte_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: tx byte %0d is %02h, expected %02h",
                     $time, tx_seen % 17, got, exp);
            byte_errors++;
        end
    endtask

    task automatic check_last(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: tx_last is %b on byte %0d, expected %b",
                     $time, got, tx_seen % 17, exp);
            last_errors++;
        end
    endtask

    task automatic expect_response(input fib_pkg::prefix_t p, input fib_pkg::meta_t m);
        logic [8*17-1:0] resp;
        resp = ref_response(p, m);
        for (int i = 0; i < 17; i++) begin
            exp_bytes.push_back(resp[(17-i)*8-1 -: 8]);
            exp_last.push_back(i == 16);
        end
    endtask

    // Optional idle gap, then hold the byte until rx_ready takes it
    task automatic send_byte(input fib_pkg::byte_t b, input bit gaps);
        int idle;
        idle = gaps ? ({$random(seed)} % 3) : 0;
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b1;
        rx_byte  = b;
        @(negedge clk);
        while (!rx_ready) @(negedge clk);
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic announce(input fib_pkg::prefix_t p, input fib_pkg::meta_t m,
                            input bit gaps);
        send_byte(m, gaps);
        for (int i = 0; i < 8; i++) begin
            send_byte(p[63-i*8 -: 8], gaps);
        end
        model_bits[model_key(m[5:0], ref_hash(p))] = 1'b1;
    endtask

    task automatic issue_lookup(input fib_pkg::prefix_t p, input fib_pkg::meta_t m);
        expect_response(p, m);
        lookup_valid    = 1'b1;
        lookup_prefix   = p;
        lookup_metadata = m;
        @(negedge clk);
        while (!lookup_ready) @(negedge clk);
        @(posedge clk);
        #1;
        lookup_valid = 1'b0;
    endtask

    // Table write lands within 3 edges of the last byte
    task automatic settle();
        repeat (4) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        while (exp_bytes.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Back-pressure drawn once per cycle, mode sampled at the edge
    initial begin
        tx_ready = 1'b1;
        forever begin
            @(posedge clk);
            bp_now = bp_enable;
            #1;
            tx_ready = bp_now ? 1'($random(bp_seed)) : 1'b1;
        end
    end

    // Compare accepted tx bytes, sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            if (exp_bytes.size() == 0) begin
                $display("Response byte %02h arrived at %0t with no lookup outstanding",
                         tx_byte, $time);
                proto_errors++;
            end else begin
                check_byte(tx_byte, exp_bytes.pop_front());
                check_last(tx_last, exp_last.pop_front());
            end
            tx_seen++;
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles, %0d response bytes never arrived",
                 cycle_count, exp_bytes.size());
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        bp_enable       = 1'b0;
        rx_valid        = 1'b0;
        rx_byte         = '0;
        lookup_valid    = 1'b0;
        lookup_prefix   = '0;
        lookup_metadata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        settle();

        // Empty table, search runs down to length 0
        issue_lookup(rand_prefix(), {2'b00, 6'd0});
        issue_lookup(rand_prefix(), {2'b01, 6'd5});
        issue_lookup(rand_prefix(), {2'b11, 6'd63});
        issue_lookup(rand_prefix(), 8'($random(seed)));
        drain();

        // Exact match, bit 6 set to show it is ignored
        p2 = rand_prefix();
        announce(p2, {2'b01, 6'd20}, 1'b0);
        settle();
        issue_lookup(p2, {2'b01, 6'd20});
        drain();

        // Shorter match reached after clearing bits 30 down to 11
        p3      = rand_prefix();
        reduced = p3;
        for (int b = 11; b <= 30; b++) begin
            reduced[b] = 1'b0;
        end
        announce(reduced, {2'b00, 6'd10}, 1'b0);
        settle();
        issue_lookup(p3, {2'b00, 6'd30});
        drain();

        // Back-to-back lookups under response back-pressure
        bp_enable = 1'b1;
        issue_lookup(p2, {2'b00, 6'd20});
        issue_lookup(p3, {2'b10, 6'd30});
        for (int i = 0; i < 4; i++) begin
            issue_lookup(rand_prefix(), 8'($random(seed)));
        end
        drain();

        // Announcements with rx gaps, then known and unknown lookups
        for (int i = 0; i < 5; i++) begin
            learned_prefix[i] = rand_prefix();
            learned_meta[i]   = 8'($random(seed));
            announce(learned_prefix[i], learned_meta[i], 1'b1);
        end
        settle();
        for (int i = 0; i < 5; i++) begin
            issue_lookup(learned_prefix[i], learned_meta[i]);
        end
        for (int i = 0; i < 3; i++) begin
            issue_lookup(rand_prefix(), 8'($random(seed)));
        end
        drain();
        settle();

        if (tx_seen != N_LOOKUPS * 17) begin
            $display("Saw %0d response bytes in total, wanted %0d", tx_seen, N_LOOKUPS * 17);
            proto_errors++;
        end
        $display("Errors: %0d byte, %0d last, %0d protocol",
                 byte_errors, last_errors, proto_errors);
        if ((byte_errors + last_errors + proto_errors) == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fib_table.f */
source/fib_pkg.sv
source/fib_hash.sv
source/fib_ingest.sv
source/fib_valid_table.sv
source/fib_lpm_search.sv
source/fib_tx_serializer.sv
source/fib_table.sv
verif/fib_table_props.sv
verif/fib_table_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fib_table simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timing \
    --timescale 1ns/100ps \
    --top-module fib_table_tb \
    -Mdir "$OBJ" -o fib_table_sim \
    -f fib_table.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/fib_table_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -q "^Testbench passed$" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

exit 0
